// File: hw/corr_cfg.svh
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

// Array size
`define CORR_ANTENNAS 4

// Block and frame lengths
`define CORR_COUNT 16  // Samples per block
`define CORR_BLOCKS 4  // Blocks per visibility frame

// Datapath widths
`define CORR_PSUM_BITS 7  // Holds +/- 2*CORR_COUNT
`define CORR_ACCUM_BITS 24

`endif

// File: hw/sig_pkg.sv
`include "corr_cfg.svh"

package sig_pkg;

  // Sample index within one block
  localparam int SADDR_BITS = $clog2(`CORR_COUNT);

  // One bit per antenna, 1 is +1 and 0 is -1
  typedef logic [`CORR_ANTENNAS-1:0] ant_bits_t;

  // All antennas at one sample instant
  typedef struct packed {
    ant_bits_t idata;
    ant_bits_t qdata;
  } sample_t;

  typedef logic [SADDR_BITS-1:0] saddr_t;

endpackage

// File: hw/vis_pkg.sv
`include "corr_cfg.svh"

package vis_pkg;

  // Baselines without autocorrelations
  localparam int NPAIRS = 6;
  localparam int ANT_BITS = $clog2(`CORR_ANTENNAS);

  typedef logic [ANT_BITS-1:0] ant_t;
  typedef logic [$clog2(NPAIRS)-1:0] pair_t;

  // Per-block partial sum, then per-frame visibility
  typedef logic signed [`CORR_PSUM_BITS-1:0] psum_t;
  typedef logic signed [`CORR_ACCUM_BITS-1:0] vis_t;

  // Antenna numbers (a, b) for each pair index
  localparam ant_t BASELINES [0:NPAIRS-1][0:1] = '{
    '{ant_t'(0), ant_t'(1)},
    '{ant_t'(0), ant_t'(2)},
    '{ant_t'(0), ant_t'(3)},
    '{ant_t'(1), ant_t'(2)},
    '{ant_t'(1), ant_t'(3)},
    '{ant_t'(2), ant_t'(3)}
  };

endpackage

// File: hw/cor_step_if.sv
`timescale 1ns/10ps

interface cor_step_if;

  logic                 step_valid;
  sig_pkg::saddr_t      step_addr;
  vis_pkg::pair_t       step_pair;
  logic                 step_first;  // First sample of a pair
  logic                 step_last;   // Last sample of a pair
  logic                 blk_first;   // First block of the frame
  logic                 blk_last;    // Last block of the frame

  modport ctrl (
    output step_valid, step_addr, step_pair, step_first, step_last, blk_first, blk_last
  );

  modport rd (input step_addr);

  modport core (input step_valid, step_pair, step_first, step_last, blk_first, blk_last);

endinterface

// File: hw/psum_if.sv
`timescale 1ns/10ps

interface psum_if;

  logic           ps_valid;
  vis_pkg::pair_t ps_pair;
  logic           ps_first;  // Block flags, not pair flags
  logic           ps_last;
  vis_pkg::psum_t ps_re;
  vis_pkg::psum_t ps_im;

  modport src (
    output ps_valid, ps_pair, ps_first, ps_last, ps_re, ps_im
  );

  modport dst (
    input ps_valid, ps_pair, ps_first, ps_last, ps_re, ps_im
  );

endinterface

// File: hw/sig_buffer.sv
`timescale 1ns/10ps
`include "corr_cfg.svh"

module sig_buffer (
  input  logic             vis_clock,
  input  logic             vis_reset,
  input  logic             sig_valid_i,
  input  sig_pkg::sample_t sig_sample_i,
  cor_step_if.rd           step,
  output logic             blk_ready_o,
  output sig_pkg::sample_t rd_sample_o
);

  // Two banks, one filling while the other is replayed
  sig_pkg::sample_t mem [0:1][0:`CORR_COUNT-1];

  sig_pkg::saddr_t wr_ptr;
  logic            wr_bank;
  logic            wr_end;

  assign wr_end = (wr_ptr == sig_pkg::saddr_t'(`CORR_COUNT - 1));

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      wr_ptr      <= '0;
      wr_bank     <= 1'b0;
      blk_ready_o <= 1'b0;
    end else begin
      blk_ready_o <= sig_valid_i && wr_end;  // Follows the final write
      if (sig_valid_i) begin
        if (wr_end) begin
          wr_ptr  <= '0;
          wr_bank <= ~wr_bank;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge vis_clock) begin
    if (sig_valid_i) begin
      mem[wr_bank][wr_ptr] <= sig_sample_i;
    end
    rd_sample_o <= mem[~wr_bank][step.step_addr];  // Idle bank only
  end

  // Input pacing leaves room for the replay of each block
  property p_sample_spacing;
    @(posedge vis_clock) disable iff (vis_reset)
      sig_valid_i |=> !sig_valid_i [*7];
  endproperty

  a_sample_spacing: assert property (p_sample_spacing)
    else $error("sig_valid_i strobes closer than 8 cycles");

endmodule

// File: hw/corr_control.sv
`timescale 1ns/10ps
`include "corr_cfg.svh"

module corr_control (
  input  logic     vis_clock,
  input  logic     vis_reset,
  input  logic     blk_ready_i,
  cor_step_if.ctrl step,
  output logic     start_o,
  output logic     frame_o
);

  localparam int BLK_BITS = (`CORR_BLOCKS > 1) ? $clog2(`CORR_BLOCKS) : 1;

  logic                busy;
  vis_pkg::pair_t      pair;
  sig_pkg::saddr_t     samp;
  logic [BLK_BITS-1:0] blk_cnt;
  logic                samp_end;
  logic                pair_end;
  logic                blk_end;

  assign samp_end = (samp == sig_pkg::saddr_t'(`CORR_COUNT - 1));
  assign pair_end = (pair == vis_pkg::pair_t'(vis_pkg::NPAIRS - 1));
  assign blk_end  = (blk_cnt == BLK_BITS'(`CORR_BLOCKS - 1));

  // Pair is the outer loop, sample the inner one
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      busy    <= 1'b0;
      pair    <= '0;
      samp    <= '0;
      blk_cnt <= '0;
    end else if (!busy) begin
      if (blk_ready_i) begin
        busy <= 1'b1;
        pair <= '0;
        samp <= '0;
      end
    end else if (samp_end) begin
      samp <= '0;
      if (pair_end) begin
        busy    <= 1'b0;  // Block done
        blk_cnt <= blk_end ? '0 : blk_cnt + 1'b1;
      end else begin
        pair <= pair + 1'b1;
      end
    end else begin
      samp <= samp + 1'b1;
    end
  end

  // Status flags, set once by the first replay after reset
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      start_o <= 1'b0;
      frame_o <= 1'b0;
    end else if (blk_ready_i && !busy && !frame_o) begin
      start_o <= 1'b1;
      frame_o <= 1'b1;
    end else begin
      start_o <= 1'b0;
    end
  end

  assign step.step_valid = busy;
  assign step.step_addr  = samp;
  assign step.step_pair  = pair;
  assign step.step_first = (samp == '0);
  assign step.step_last  = samp_end;
  assign step.blk_first  = (blk_cnt == '0);
  assign step.blk_last   = blk_end;

  // A new block must not land while the previous one is still replaying
  a_no_overrun: assert property (
    @(posedge vis_clock) disable iff (vis_reset) blk_ready_i |-> !busy
  ) else $error("block overrun, blk_ready during replay");

endmodule

// File: hw/corr_core.sv
`timescale 1ns/10ps

module corr_core (
  input  logic             vis_clock,
  input  logic             vis_reset,
  cor_step_if.core         step,
  input  sig_pkg::sample_t rd_sample_i,
  psum_if.src              ps
);

  logic           valid_d;
  logic           first_d;
  logic           last_d;
  logic           bfirst_d;
  logic           blast_d;
  vis_pkg::pair_t pair_d;
  vis_pkg::ant_t  ant_a;
  vis_pkg::ant_t  ant_b;
  logic           ai, aq, bi, bq;
  vis_pkg::psum_t re_term, im_term;
  vis_pkg::psum_t acc_re, acc_im;
  vis_pkg::psum_t sum_re, sum_im;

  // One-bit sample product, equal bits give +1
  function automatic vis_pkg::psum_t pm1(input logic same);
    return same ? vis_pkg::psum_t'(1) : vis_pkg::psum_t'(-1);
  endfunction

  // Step controls lag one cycle to meet the read data
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      valid_d  <= 1'b0;
      first_d  <= 1'b0;
      last_d   <= 1'b0;
      bfirst_d <= 1'b0;
      blast_d  <= 1'b0;
    end else begin
      valid_d  <= step.step_valid;
      first_d  <= step.step_first;
      last_d   <= step.step_last;
      bfirst_d <= step.blk_first;
      blast_d  <= step.blk_last;
    end
  end

  always_ff @(posedge vis_clock) begin
    pair_d <= step.step_pair;
  end

  assign ant_a = vis_pkg::BASELINES[pair_d][0];
  assign ant_b = vis_pkg::BASELINES[pair_d][1];
  assign ai    = rd_sample_i.idata[ant_a];
  assign aq    = rd_sample_i.qdata[ant_a];
  assign bi    = rd_sample_i.idata[ant_b];
  assign bq    = rd_sample_i.qdata[ant_b];

  assign re_term = pm1(ai ~^ bi) + pm1(aq ~^ bq);  // ai*bi + aq*bq
  assign im_term = pm1(aq ~^ bi) - pm1(ai ~^ bq);  // aq*bi - ai*bq

  assign sum_re = first_d ? re_term : acc_re + re_term;
  assign sum_im = first_d ? im_term : acc_im + im_term;

  always_ff @(posedge vis_clock) begin
    if (valid_d) begin
      acc_re <= sum_re;
      acc_im <= sum_im;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      ps.ps_valid <= 1'b0;
    end else begin
      ps.ps_valid <= valid_d && last_d;
    end
  end

  // Finished sum with the pair and block flags
  always_ff @(posedge vis_clock) begin
    if (valid_d && last_d) begin
      ps.ps_re    <= sum_re;
      ps.ps_im    <= sum_im;
      ps.ps_pair  <= pair_d;
      ps.ps_first <= bfirst_d;
      ps.ps_last  <= blast_d;
    end
  end

endmodule

// File: hw/vis_accum.sv
`timescale 1ns/10ps

module vis_accum (
  input  logic          vis_clock,
  input  logic          vis_reset,
  psum_if.dst           ps,
  output logic          vis_valid_o,
  output logic          vis_last_o,
  output vis_pkg::vis_t vis_re_o,
  output vis_pkg::vis_t vis_im_o
);

  // Running sums, one entry per baseline
  vis_pkg::vis_t re_mem [0:vis_pkg::NPAIRS-1];
  vis_pkg::vis_t im_mem [0:vis_pkg::NPAIRS-1];

  vis_pkg::vis_t base_re, base_im;
  vis_pkg::vis_t new_re, new_im;
  logic          emit;

  // First block of a frame starts from zero
  assign base_re = ps.ps_first ? '0 : re_mem[ps.ps_pair];
  assign base_im = ps.ps_first ? '0 : im_mem[ps.ps_pair];
  assign new_re  = base_re + vis_pkg::vis_t'(ps.ps_re);
  assign new_im  = base_im + vis_pkg::vis_t'(ps.ps_im);
  assign emit    = ps.ps_valid && ps.ps_last;

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      vis_valid_o <= 1'b0;
      vis_last_o  <= 1'b0;
    end else begin
      vis_valid_o <= emit;
      vis_last_o  <= emit && (ps.ps_pair == vis_pkg::pair_t'(vis_pkg::NPAIRS - 1));
    end
  end

  always_ff @(posedge vis_clock) begin
    if (ps.ps_valid) begin
      re_mem[ps.ps_pair] <= new_re;
      im_mem[ps.ps_pair] <= new_im;
    end
    if (emit) begin
      vis_re_o <= new_re;  // Complete frame for this pair
      vis_im_o <= new_im;
    end
  end

  // Pair index comes from the control counter, via the core pipeline
  a_pair_range: assert property (
    @(posedge vis_clock) disable iff (vis_reset)
      ps.ps_valid |-> (ps.ps_pair < vis_pkg::NPAIRS)
  ) else $error("partial sum with out-of-range pair %0d", ps.ps_pair);

endmodule

// File: hw/vis_correlator.sv
`timescale 1ns/10ps
`include "corr_cfg.svh"

module vis_correlator (
  input  logic                               vis_clock,
  input  logic                               vis_reset,
  input  logic                               sig_valid_i,
  input  logic        [`CORR_ANTENNAS-1:0]   sig_idata_i,
  input  logic        [`CORR_ANTENNAS-1:0]   sig_qdata_i,
  output logic                               vis_start_o,
  output logic                               vis_frame_o,
  output logic                               vis_valid_o,
  output logic                               vis_last_o,
  output logic signed [`CORR_ACCUM_BITS-1:0] vis_revis_o,
  output logic signed [`CORR_ACCUM_BITS-1:0] vis_imvis_o
);

  sig_pkg::sample_t sig_sample;
  sig_pkg::sample_t rd_sample;
  logic             blk_ready;

  cor_step_if step_bus ();
  psum_if     psum_bus ();

  assign sig_sample.idata = sig_idata_i;
  assign sig_sample.qdata = sig_qdata_i;

  sig_buffer sig_buffer_inst (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .sig_valid_i (sig_valid_i),
    .sig_sample_i(sig_sample),
    .step        (step_bus.rd),
    .blk_ready_o (blk_ready),
    .rd_sample_o (rd_sample)
  );

  corr_control corr_control_inst (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .blk_ready_i(blk_ready),
    .step       (step_bus.ctrl),
    .start_o    (vis_start_o),
    .frame_o    (vis_frame_o)
  );

  corr_core corr_core_inst (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .step       (step_bus.core),
    .rd_sample_i(rd_sample),
    .ps         (psum_bus.src)
  );

  vis_accum vis_accum_inst (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .ps         (psum_bus.dst),
    .vis_valid_o(vis_valid_o),
    .vis_last_o (vis_last_o),
    .vis_re_o   (vis_revis_o),
    .vis_im_o   (vis_imvis_o)
  );

endmodule

// File: sim/tb_vis_correlator.sv
`timescale 1ns/10ps
`include "corr_cfg.svh"

module tb_vis_correlator;

  localparam int FRAME_LEN   = `CORR_BLOCKS * `CORR_COUNT;
  localparam int NUM_FRAMES  = 5;
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_LEN * 8 * 8 + 2000;
  localparam int FULL_SCALE  = 2 * FRAME_LEN;  // Both real terms +1 on every sample

  logic                               vis_clock;
  logic                               vis_reset;
  logic                               sig_valid;
  logic        [`CORR_ANTENNAS-1:0]   sig_idata;
  logic        [`CORR_ANTENNAS-1:0]   sig_qdata;
  logic                               vis_start;
  logic                               vis_frame;
  logic                               vis_valid;
  logic                               vis_last;
  logic signed [`CORR_ACCUM_BITS-1:0] vis_re;
  logic signed [`CORR_ACCUM_BITS-1:0] vis_im;

  // One frame of stimulus, kept for the reference model
  logic [`CORR_ANTENNAS-1:0] stim_i [0:FRAME_LEN-1];
  logic [`CORR_ANTENNAS-1:0] stim_q [0:FRAME_LEN-1];

  int     exp_re_q [$];
  int     exp_im_q [$];
  integer got_re_q [$];
  integer got_im_q [$];
  logic   got_last_q [$];

  logic [31:0] lfsr;
  int          errors = 0;
  int          checks = 0;
  int          checks_started = 0;
  int          checks_done = 0;
  int          start_count = 0;
  logic        frame_seen = 1'b0;
  logic        frame_dropped = 1'b0;

  vis_correlator vis_correlator_inst (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .sig_valid_i(sig_valid),
    .sig_idata_i(sig_idata),
    .sig_qdata_i(sig_qdata),
    .vis_start_o(vis_start),
    .vis_frame_o(vis_frame),
    .vis_valid_o(vis_valid),
    .vis_last_o (vis_last),
    .vis_revis_o(vis_re),
    .vis_imvis_o(vis_im)
  );

  always #4 vis_clock = ~vis_clock;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic next_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic int pm(input logic b);
    return b ? 1 : -1;  // Bit 1 is +1
  endfunction

  // Output side, sampled away from the active edge
  always @(negedge vis_clock) begin
    if (!vis_reset) begin
      if (vis_valid) begin
        got_re_q.push_back(vis_re);
        got_im_q.push_back(vis_im);
        got_last_q.push_back(vis_last);
      end
      if (vis_start) start_count++;
      if (frame_seen && !vis_frame) frame_dropped = 1'b1;
      if (vis_frame) frame_seen = 1'b1;
    end
  end

  // Expected visibilities straight from the correlation rule
  task push_model(input int from_pair);
    int p, n, a, b, re, im;
    for (p = from_pair; p < vis_pkg::NPAIRS; p++) begin
      a  = vis_pkg::BASELINES[p][0];
      b  = vis_pkg::BASELINES[p][1];
      re = 0;
      im = 0;
      for (n = 0; n < FRAME_LEN; n++) begin
        re += pm(stim_i[n][a]) * pm(stim_i[n][b]);
        re += pm(stim_q[n][a]) * pm(stim_q[n][b]);
        im += pm(stim_q[n][a]) * pm(stim_i[n][b]);
        im -= pm(stim_i[n][a]) * pm(stim_q[n][b]);
      end
      exp_re_q.push_back(re);
      exp_im_q.push_back(im);
    end
  endtask

  task fill_random();
    int n, a;
    for (n = 0; n < FRAME_LEN; n++) begin
      for (a = 0; a < `CORR_ANTENNAS; a++) begin
        stim_i[n][a] = next_bit();
        stim_q[n][a] = next_bit();
      end
    end
  endtask

  // Pairs arrive in order, six per frame
  task check_frame();
    int     wait_cycles, p, exp_re, exp_im;
    integer got_re, got_im;
    logic   got_last;
    wait_cycles = 0;
    while (got_re_q.size() < vis_pkg::NPAIRS && wait_cycles < 400) begin
      @(negedge vis_clock);
      wait_cycles++;
    end
    if (got_re_q.size() < vis_pkg::NPAIRS) begin
      $display("timed out waiting for a frame, only %0d visibilities arrived", got_re_q.size());
      errors++;
      got_re_q.delete();
      got_im_q.delete();
      got_last_q.delete();
      exp_re_q.delete();
      exp_im_q.delete();
    end else begin
      for (p = 0; p < vis_pkg::NPAIRS; p++) begin
        got_re   = got_re_q.pop_front();
        got_im   = got_im_q.pop_front();
        got_last = got_last_q.pop_front();
        exp_re   = exp_re_q.pop_front();
        exp_im   = exp_im_q.pop_front();
        checks += 3;
        if (got_re !== exp_re) begin
          $display("error vis_revis_o pair %0d: got %h expected %h", p, got_re, exp_re);
          errors++;
        end
        if (got_im !== exp_im) begin
          $display("error vis_imvis_o pair %0d: got %h expected %h", p, got_im, exp_im);
          errors++;
        end
        if (got_last !== (p == vis_pkg::NPAIRS - 1)) begin
          $display("error vis_last_o pair %0d: got %h expected %h", p, got_last,
                   p == vis_pkg::NPAIRS - 1);
          errors++;
        end
      end
    end
    checks_done++;
  endtask

  // One sample every 8 cycles, check runs alongside the next frame
  task run_frame();
    int n;
    for (n = 0; n < FRAME_LEN; n++) begin
      @(negedge vis_clock);
      sig_valid = 1'b1;
      sig_idata = stim_i[n];
      sig_qdata = stim_q[n];
      @(negedge vis_clock);
      sig_valid = 1'b0;
      repeat (6) @(negedge vis_clock);
    end
    checks_started++;
    fork
      check_frame();
    join_none
  endtask

  task test_idle_after_reset();
    int c;
    for (c = 0; c < 16; c++) begin
      @(negedge vis_clock);
      checks++;
      if ({vis_start, vis_frame, vis_valid} !== 3'b000) begin
        $display("error vis_start_o/vis_frame_o/vis_valid_o: got %h expected %h",
                 {vis_start, vis_frame, vis_valid}, 3'b000);
        errors++;
      end
    end
  endtask

  task test_constant_frame();
    int n, p;
    for (n = 0; n < FRAME_LEN; n++) begin
      stim_i[n] = '1;  // Same on every antenna
      stim_q[n] = '0;
    end
    for (p = 0; p < vis_pkg::NPAIRS; p++) begin
      exp_re_q.push_back(FULL_SCALE);
      exp_im_q.push_back(0);
    end
    run_frame();
    checks += 2;
    if (start_count != 1) begin
      $display("error vis_start_o pulse count: got %h expected %h", start_count, 1);
      errors++;
    end
    if (vis_frame !== 1'b1) begin
      $display("error vis_frame_o: got %h expected %h", vis_frame, 1'b1);
      errors++;
    end
  endtask

  task test_random_frame();
    fill_random();
    push_model(0);
    run_frame();
  endtask

  task test_two_random_frames();
    fill_random();
    push_model(0);
    run_frame();
    fill_random();
    push_model(0);
    run_frame();
  endtask

  task test_rotated_antenna();
    int n;
    fill_random();
    for (n = 0; n < FRAME_LEN; n++) begin
      stim_i[n][1] = ~stim_q[n][0];  // j*a gives I = -Q0, Q = I0
      stim_q[n][1] = stim_i[n][0];
    end
    exp_re_q.push_back(0);
    exp_im_q.push_back(-FULL_SCALE);
    push_model(1);
    run_frame();
  endtask

  task check_flags_held();
    checks += 3;
    if (start_count != 1) begin
      $display("error vis_start_o pulse count: got %h expected %h", start_count, 1);
      errors++;
    end
    if (frame_dropped || vis_frame !== 1'b1) begin
      $display("vis_frame_o went low after the first replay began");
      errors++;
    end
    if (got_re_q.size() != 0) begin
      $display("%0d visibilities arrived beyond the expected frames", got_re_q.size());
      errors++;
    end
  endtask

  initial begin
    vis_clock = 1'b0;
    vis_reset = 1'b1;
    sig_valid = 1'b0;
    sig_idata = '0;
    sig_qdata = '0;
    lfsr      = 32'h3121;
    repeat (4) @(posedge vis_clock);
    @(negedge vis_clock);
    vis_reset = 1'b0;

    test_idle_after_reset();
    test_constant_frame();
    test_random_frame();
    test_two_random_frames();
    test_rotated_antenna();

    while (checks_done < checks_started) @(negedge vis_clock);
    check_flags_held();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Sized from the frames sent, plus a fixed margin
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before all tests completed", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: vis_correlator.f
+incdir+hw
hw/sig_pkg.sv
hw/vis_pkg.sv
hw/cor_step_if.sv
hw/psum_if.sv
hw/sig_buffer.sv
hw/corr_control.sv
hw/corr_core.sv
hw/vis_accum.sv
hw/vis_correlator.sv
sim/tb_vis_correlator.sv
